// ==== compile.f ====
src/readout_pkg.sv
src/host_pkg.sv
src/sense_if.sv
src/host_regs.sv
src/conversion_ctrl.sv
src/sign_capture.sv
src/step_recorder.sv
src/result_packer.sv
src/readout_top.sv
dv/readout_checker.sv
dv/readout_tb.sv

// ==== dv/readout_checker.sv ====
`timescale 1ns/1ps

module readout_checker (
	input logic clk,
	input logic rst,
	input logic wb_ack,
	input logic wb_we,
	input logic [host_pkg::wb_addr_width-1:0] wb_adr,
	input logic [host_pkg::wb_data_width-1:0] wb_dat_r,
	input logic neuron_reset_trigger,
	input logic spi_read_trigger,
	input logic inference_off,
	input logic exp_en,
	input logic [host_pkg::wb_data_width-1:0] exp_data,
	input logic [host_pkg::wb_data_width-1:0] exp_care,
	output int checks,
	output int errors
);

	logic rst_q = 1'b1;
	logic ack_q = 1'b0;
	int nrn_len = 0;
	int rd_len = 0;

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp_val);
		checks++;
		if (got !== exp_val) begin
			errors++;
			$display("ERROR %s got %h expected %h at %0t", name, got, exp_val, $time);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	always @(posedge clk) begin
		rst_q <= rst;
		ack_q <= wb_ack;
		if (rst) begin
			nrn_len = 0;
			rd_len = 0;
		end else begin
			if (rst_q) begin // first cycle out of reset
				check_val("neuron_reset_trigger", neuron_reset_trigger, 0);
				check_val("spi_read_trigger", spi_read_trigger, 0);
				check_val("inference_off", inference_off, 0);
			end

			// ----------------------------------------------------------------------
			// wishbone reads
			// ----------------------------------------------------------------------
			if (wb_ack && ack_q)
				report("wb_ack is high in two consecutive cycles");
			if (wb_ack && !wb_we && exp_en)
				check_val($sformatf("wb_dat_r[%h]", wb_adr), wb_dat_r & exp_care,
					exp_data & exp_care);
			if (wb_ack && !wb_we && wb_adr == host_pkg::addr_ctrl &&
					wb_dat_r[host_pkg::status_done_bit] && !wb_dat_r[host_pkg::status_busy_bit])
				check_val("inference_off", inference_off, 0); // released after done

			// ----------------------------------------------------------------------
			// array pins
			// ----------------------------------------------------------------------
			if (neuron_reset_trigger && spi_read_trigger)
				report("neuron and read triggers are high in the same cycle");
			if ((neuron_reset_trigger || spi_read_trigger) && !inference_off)
				report("array trigger is high while inference_off is low");
			if (neuron_reset_trigger)
				nrn_len++;
			else if (nrn_len != 0) begin
				check_val("neuron_reset_trigger length", nrn_len, readout_pkg::trig_cycles);
				nrn_len = 0;
			end
			if (spi_read_trigger)
				rd_len++;
			else if (rd_len != 0) begin
				check_val("spi_read_trigger length", rd_len, readout_pkg::trig_cycles);
				rd_len = 0;
			end
		end
	end

endmodule

// ==== dv/readout_tb.sv ====
`timescale 1ns/1ps

module readout_tb;

	localparam int ack_limit = 16;
	localparam int poll_limit = 2000;

	typedef struct packed {
		logic [31:0] mask;
		logic [31:0] ref_bits;
		logic [6:0] fmax; // largest flip iteration of the enabled columns
		logic [31:0] stuck; // columns that never flip
		logic [6:0] reads; // expected read count in status
	} row_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic wb_cyc = 1'b0;
	logic wb_stb = 1'b0;
	logic wb_we = 1'b0;
	logic [host_pkg::wb_addr_width-1:0] wb_adr = '0;
	logic [host_pkg::wb_data_width-1:0] wb_dat_w = '0;
	logic [host_pkg::wb_data_width-1:0] wb_dat_r;
	logic wb_ack;
	logic neuron_reset_trigger;
	logic spi_read_trigger;
	logic inference_off;
	logic neuron_idle = 1'b0;
	logic spi_valid = 1'b0;
	readout_pkg::col_t spi_row = '0;
	logic exp_en = 1'b0;
	logic [31:0] exp_data = '0;
	logic [31:0] exp_care = '0;
	int checks;
	int errors;
	int timeouts = 0;
	logic [31:0] rng = 32'h06bbd5ce;
	row_t rows [6];
	readout_pkg::col_t cur_ref = '0;
	int flip_at [readout_pkg::col_count];
	int read_idx = 0;
	int dly = 0;
	logic rd_pend = 1'b0;

	always #4 clk = ~clk;

	readout_top readout_top_i (.*);
	readout_checker readout_checker_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// row seen by the array at a given read index
	function automatic readout_pkg::col_t model_row(input int idx);
		readout_pkg::col_t r;
		for (int c = 0; c < readout_pkg::col_count; c++)
			r[c] = cur_ref[c] ^ (idx >= flip_at[c]);
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// array model, idle and valid come 1 to 6 cycles after each trigger
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		spi_valid <= 1'b0;
		if (!inference_off)
			read_idx <= 0;
		if (neuron_reset_trigger || spi_read_trigger) begin
			rng = xorshift(rng);
			dly <= 1 + rng % 6;
			rd_pend <= spi_read_trigger;
			if (neuron_reset_trigger)
				neuron_idle <= 1'b0;
		end else if (dly == 1) begin
			dly <= 0;
			if (rd_pend) begin
				spi_valid <= 1'b1;
				spi_row <= model_row(read_idx);
				read_idx <= read_idx + 1;
			end else
				neuron_idle <= 1'b1;
		end else if (dly != 0)
			dly <= dly - 1;
	end

	task automatic finish_run;
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	task automatic stop_on_timeout(input string what);
		timeouts++;
		$display("timeout: %s at %0t", what, $time);
		finish_run();
	endtask

	// one wishbone cycle, en marks a read that the checker compares
	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
			input logic en, input logic [31:0] exp_val, input logic [31:0] care,
			output logic [31:0] rdat);
		int n;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdat;
		exp_en <= en;
		exp_data <= exp_val;
		exp_care <= care;
		n = 0;
		@(posedge clk);
		while (!wb_ack && n < ack_limit) begin
			@(posedge clk);
			n++;
		end
		if (!wb_ack)
			stop_on_timeout("no wb_ack for a Wishbone cycle");
		rdat = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		exp_en <= 1'b0;
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] st;
		logic [31:0] word;
		logic [6:0] step;
		int hi;
		int polls;
		int c;
		rows[0] = '{32'hffffffff, 32'ha5a5a5a5, 7'd12, 32'h00000000, 7'd13};
		rows[1] = '{32'h0f0f00ff, 32'h3c3c3c3c, 7'd30, 32'hf0f0ff00, 7'd31};
		rows[2] = '{32'h00000000, 32'hffff0000, 7'd5, 32'h00000000, 7'd1};
		rows[3] = '{32'h80000001, 32'h00000001, 7'd100, 32'h00000000, 7'd101};
		rows[4] = '{32'h7fffffff, 32'h12345678, 7'd20, 32'h00010000, 7'd101};
		rows[5] = '{32'hffffffff, 32'h00000000, 7'd1, 32'h00000000, 7'd2};
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		wb_access(0, host_pkg::addr_ctrl, 0, 1, 0, '1, rd);
		wb_access(0, host_pkg::addr_mask, 0, 1, 0, '1, rd);
		wb_access(0, 4'd2, 0, 1, 0, '1, rd); // unmapped
		for (int w = 0; w < readout_pkg::result_words; w++)
			wb_access(0, host_pkg::addr_result_base + w, 0, 1, 0, '1, rd);

		foreach (rows[r]) begin
			// flip iterations, highest enabled column pinned to fmax
			hi = -1;
			for (c = 0; c < readout_pkg::col_count; c++) begin
				rng = xorshift(rng);
				flip_at[c] = 1 + rng % rows[r].fmax;
				if (rows[r].mask[c])
					hi = c;
			end
			if (hi >= 0)
				flip_at[hi] = rows[r].fmax;
			for (c = 0; c < readout_pkg::col_count; c++)
				if (rows[r].stuck[c])
					flip_at[c] = 127;
			cur_ref = rows[r].ref_bits;

			wb_access(1, host_pkg::addr_mask, rows[r].mask, 0, 0, 0, rd);
			wb_access(0, host_pkg::addr_mask, 0, 1, rows[r].mask, '1, rd);
			wb_access(1, host_pkg::addr_ctrl, 1, 0, 0, 0, rd);
			wb_access(0, host_pkg::addr_ctrl, 0, 1, 32'h1, 32'h3, rd); // busy, not done
			polls = 0;
			do begin
				wb_access(0, host_pkg::addr_ctrl, 0, 0, 0, 0, st);
				polls++;
				if (polls == 8 && rows[r].reads > 10)
					wb_access(1, host_pkg::addr_ctrl, 1, 0, 0, 0, rd); // must be dropped
			end while (!st[host_pkg::status_done_bit] && polls < poll_limit);
			if (!st[host_pkg::status_done_bit])
				stop_on_timeout("conversion did not reach done");

			wb_access(0, host_pkg::addr_ctrl, 0, 1,
				(32'(rows[r].reads) << host_pkg::status_reads_lsb) |
				(32'h1 << host_pkg::status_done_bit), '1, rd);
			for (int w = 0; w < readout_pkg::result_words; w++) begin
				word = '0;
				for (int j = 0; j < readout_pkg::cols_per_word; j++) begin
					c = w * readout_pkg::cols_per_word + j;
					step = (rows[r].mask[c] && flip_at[c] <= readout_pkg::max_iter) ? flip_at[c] : 0;
					word[j*8 +: 8] = {cur_ref[c], step};
				end
				wb_access(0, host_pkg::addr_result_base + w, 0, 1, word, '1, rd);
			end
		end
		finish_run();
	end

endmodule

// ==== src/conversion_ctrl.sv ====
`timescale 1ns/1ps

module conversion_ctrl (
	input logic clk,
	input logic rst,
	input logic start,
	input logic all_found,
	input logic neuron_idle,
	input logic spi_valid,
	input readout_pkg::col_t spi_row,
	output logic neuron_reset_trigger,
	output logic spi_read_trigger,
	output logic inference_off,
	output logic busy,
	output logic done,
	output readout_pkg::step_t reads,
	sense_if.ctrl sense
);

	typedef enum logic [2:0] {
		s_idle,
		s_nrn_trig,
		s_nrn_wait,
		s_rd_trig,
		s_rd_wait,
		s_sample,
		s_check
	} state_t;

	state_t state;
	logic [$clog2(readout_pkg::trig_cycles)-1:0] trig_cnt;
	logic trig_last;
	readout_pkg::step_t iter;

	assign trig_last = (trig_cnt == readout_pkg::trig_cycles - 1);

	// ------------------------------------------------------------------------
	// step sequence
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			trig_cnt <= '0;
			iter <= '0;
			reads <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				s_idle: if (start) begin
					state <= s_nrn_trig;
					trig_cnt <= '0;
					iter <= '0;
					reads <= '0;
					done <= 1'b0;
				end
				s_nrn_trig, s_rd_trig: begin
					trig_cnt <= trig_last ? '0 : trig_cnt + 1'b1;
					if (trig_last)
						state <= (state == s_nrn_trig) ? s_nrn_wait : s_rd_wait;
				end
				s_nrn_wait: if (neuron_idle) state <= s_rd_trig;
				s_rd_wait: if (spi_valid) state <= s_sample;
				s_sample: begin
					reads <= reads + 1'b1;
					state <= s_check; // trackers update on this edge
				end
				s_check: begin
					if (all_found || (iter == readout_pkg::max_iter)) begin
						state <= s_idle;
						done <= 1'b1;
					end else begin
						iter <= iter + 1'b1;
						state <= s_nrn_trig;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// row capture
	always_ff @(posedge clk) begin
		if (state == s_rd_wait && spi_valid)
			sense.row <= spi_row;
	end

	assign neuron_reset_trigger = (state == s_nrn_trig);
	assign spi_read_trigger = (state == s_rd_trig);
	assign busy = (state != s_idle);
	assign inference_off = busy; // held off for the whole conversion

	assign sense.sample = (state == s_sample);
	assign sense.first = (iter == 0);
	assign sense.iter = iter;

	a_reads_iter: assert property (@(posedge clk) disable iff (rst)
		(state == s_check) |-> (reads == iter + 1'b1))
		else $error("read count out of step with the iteration count");

endmodule

// ==== src/host_pkg.sv ====
package host_pkg;

	// wishbone bus sizes
	localparam int wb_data_width = 32;
	localparam int wb_addr_width = 4; // word address

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	localparam logic [wb_addr_width-1:0] addr_ctrl = 0; // ctrl on write, status on read
	localparam logic [wb_addr_width-1:0] addr_mask = 1;
	localparam logic [wb_addr_width-1:0] addr_result_base = 8;

	// status word fields
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;
	localparam int status_reads_lsb = 8; // 7 bit read count

	// ctrl write fields
	localparam int ctrl_start_bit = 0;

endpackage

// ==== src/host_regs.sv ====
`timescale 1ns/1ps

module host_regs (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [host_pkg::wb_addr_width-1:0] wb_adr,
	input logic [host_pkg::wb_data_width-1:0] wb_dat_w,
	output logic [host_pkg::wb_data_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic start,
	output readout_pkg::col_t mask,
	input logic busy,
	input logic done,
	input readout_pkg::step_t reads,
	output readout_pkg::word_idx_t word_sel,
	input logic [host_pkg::wb_data_width-1:0] result_word
);

	logic req;
	logic wr;
	logic in_result;
	logic [host_pkg::wb_data_width-1:0] status;
	logic [host_pkg::wb_data_width-1:0] rd_data;

	assign req = wb_cyc && wb_stb && !wb_ack; // no new request in the ack cycle
	assign wr = req && wb_we;

	assign in_result = (wb_adr >= host_pkg::addr_result_base) &&
		(wb_adr < host_pkg::addr_result_base + readout_pkg::result_words);
	assign word_sel = readout_pkg::word_idx_t'(wb_adr - host_pkg::addr_result_base);

	always_comb begin
		status = '0;
		status[host_pkg::status_busy_bit] = busy;
		status[host_pkg::status_done_bit] = done;
		status[host_pkg::status_reads_lsb +: readout_pkg::step_width] = reads;
	end

	// unmapped addresses read as zero
	always_comb begin
		if (wb_adr == host_pkg::addr_ctrl)
			rd_data = status;
		else if (wb_adr == host_pkg::addr_mask)
			rd_data = mask;
		else if (in_result)
			rd_data = result_word;
		else
			rd_data = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			mask <= '0;
		end else begin
			wb_ack <= req;
			start <= wr && (wb_adr == host_pkg::addr_ctrl) &&
				wb_dat_w[host_pkg::ctrl_start_bit] && !busy; // dropped while busy
			if (wr && (wb_adr == host_pkg::addr_mask))
				mask <= wb_dat_w;
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_data; // held through the ack cycle
	end

	a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else $error("start pulse reached a busy sequencer");

endmodule

// ==== src/readout_pkg.sv ====
package readout_pkg;

	// ------------------------------------------------------------------------
	// array geometry
	// ------------------------------------------------------------------------
	localparam int col_count = 32;

	typedef logic [col_count-1:0] col_t;

	// ------------------------------------------------------------------------
	// step counting and trigger timing
	// ------------------------------------------------------------------------
	localparam int step_width = 7;
	localparam int max_iter = 100; // last iteration allowed to run
	localparam int trig_cycles = 4; // high time of each trigger pulse

	typedef logic [step_width-1:0] step_t;

	// ------------------------------------------------------------------------
	// result word layout
	// ------------------------------------------------------------------------
	localparam int cols_per_word = 4; // one byte per column
	localparam int result_words = 8;

	typedef logic [2:0] word_idx_t;

endpackage

// ==== src/readout_top.sv ====
`timescale 1ns/1ps

module readout_top (
	input logic clk,
	input logic rst,

	// wishbone slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [host_pkg::wb_addr_width-1:0] wb_adr,
	input logic [host_pkg::wb_data_width-1:0] wb_dat_w,
	output logic [host_pkg::wb_data_width-1:0] wb_dat_r,
	output logic wb_ack,

	// array side
	output logic neuron_reset_trigger,
	input logic neuron_idle,
	output logic spi_read_trigger,
	input logic spi_valid,
	input readout_pkg::col_t spi_row,
	output logic inference_off
);

	logic start;
	logic all_found;
	logic busy;
	logic done;
	readout_pkg::step_t reads;
	readout_pkg::col_t mask;
	readout_pkg::col_t flips;
	readout_pkg::col_t ref_row;
	readout_pkg::step_t [readout_pkg::col_count-1:0] steps;
	readout_pkg::word_idx_t word_sel;
	logic [host_pkg::wb_data_width-1:0] result_word;

	sense_if sense_i ();

	host_regs host_regs_i (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.start(start), .mask(mask), .busy(busy), .done(done), .reads(reads),
		.word_sel(word_sel), .result_word(result_word)
	);

	conversion_ctrl conversion_ctrl_i (
		.clk(clk), .rst(rst), .start(start), .all_found(all_found),
		.neuron_idle(neuron_idle), .spi_valid(spi_valid), .spi_row(spi_row),
		.neuron_reset_trigger(neuron_reset_trigger), .spi_read_trigger(spi_read_trigger),
		.inference_off(inference_off), .busy(busy), .done(done), .reads(reads),
		.sense(sense_i.ctrl)
	);

	sign_capture sign_capture_i (
		.clk(clk), .rst(rst), .sense(sense_i.track),
		.ref_row(ref_row), .flips(flips)
	);

	step_recorder step_recorder_i (
		.clk(clk), .rst(rst), .start(start), .mask(mask), .flips(flips),
		.sense(sense_i.track), .steps(steps), .all_found(all_found)
	);

	result_packer result_packer_i (
		.ref_row(ref_row), .steps(steps), .word_sel(word_sel), .result_word(result_word)
	);

endmodule

// ==== src/result_packer.sv ====
`timescale 1ns/1ps

module result_packer (
	input readout_pkg::col_t ref_row,
	input readout_pkg::step_t [readout_pkg::col_count-1:0] steps,
	input readout_pkg::word_idx_t word_sel,
	output logic [host_pkg::wb_data_width-1:0] result_word
);

	// byte j of word w: {ref bit, step count} of column 4w+j
	for (genvar j = 0; j < readout_pkg::cols_per_word; j++) begin : g_byte
		assign result_word[j*(readout_pkg::step_width+1) +: readout_pkg::step_width+1] = {
			ref_row[word_sel*readout_pkg::cols_per_word + j],
			steps[word_sel*readout_pkg::cols_per_word + j]
		};
	end

endmodule

// ==== src/sense_if.sv ====
`timescale 1ns/1ps

// one captured read row, handed from the sequencer to both trackers
interface sense_if;

	logic sample; // one cycle, after spi_valid
	logic first; // iteration 0 carries the reference row
	readout_pkg::step_t iter;
	readout_pkg::col_t row;

	modport ctrl (
		output sample, first, iter, row
	);

	modport track (
		input sample, first, iter, row
	);

endinterface

// ==== src/sign_capture.sv ====
`timescale 1ns/1ps

module sign_capture (
	input logic clk,
	input logic rst,
	sense_if.track sense,
	output readout_pkg::col_t ref_row,
	output readout_pkg::col_t flips
);

	// reference sign comes from the iteration 0 read
	always_ff @(posedge clk) begin
		if (rst)
			ref_row <= '0;
		else if (sense.sample && sense.first)
			ref_row <= sense.row;
	end

	// columns whose sign moved away from the reference
	assign flips = (sense.sample && !sense.first) ? (sense.row ^ ref_row) : '0;

endmodule

// ==== src/step_recorder.sv ====
`timescale 1ns/1ps

module step_recorder (
	input logic clk,
	input logic rst,
	input logic start,
	input readout_pkg::col_t mask,
	input readout_pkg::col_t flips,
	sense_if.track sense,
	output readout_pkg::step_t [readout_pkg::col_count-1:0] steps,
	output logic all_found
);

	readout_pkg::col_t found;
	readout_pkg::col_t hit;

	assign hit = flips & ~found; // first flip of a column only
	assign all_found = &found;

	always_ff @(posedge clk) begin
		if (rst || start)
			found <= '0;
		else if (sense.sample)
			found <= sense.first ? ~mask : (found | hit); // disabled cols count as found
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			steps <= '0;
		end else if (sense.sample) begin
			for (int i = 0; i < readout_pkg::col_count; i++) begin
				if (hit[i])
					steps[i] <= sense.iter;
			end
		end
	end

	// counts stay within the iteration limit
	for (genvar i = 0; i < readout_pkg::col_count; i++) begin : g_chk
		a_step_range: assert property (@(posedge clk) disable iff (rst)
			steps[i] <= readout_pkg::max_iter)
			else $error("step count of column %0d beyond the last iteration", i);
	end

endmodule
